// ==== Bender.yml ====
package:
  name: k051960

sources:
  - include_dirs:
      - .
    files:
      - k051960_pkg.sv
      - video_timing_if.sv
      - video_timing.sv
      - sprite_regs.sv
      - irq_gen.sv
      - k051960.sv
      - target: simulation
        files:
          - k051960_properties.sv
          - tb_k051960.sv

// ==== irq_gen.sv ====
// Interrupt latches set by timing events, held clear while their enable is 0
// A latch stays set until the CPU writes its enable bit low
`timescale 1ns/1ns
`include "k051960_config.svh"

module irq_gen (
	input  logic               clk_6M,
	input  logic               V143,
	input  k051960_pkg::ctrl_t ctrl,
	video_timing_if.sink       tm,
	output logic               irq,
	output logic               firq,
	output logic               nmi
);

	localparam logic [8:0] NMI_MASK = 9'(`K051960_NMI_LINES - 1);

	logic       vblank_d;
	logic [2:0] evt;    // NMI, FIRQ, IRQ from top down
	logic [2:0] en;
	logic [2:0] lat;

	// Start of blank
	assign evt[0] = tm.vblank & ~vblank_d;
	// Every second line
	assign evt[1] = tm.line_start & ~tm.v_count[0];
	// Every NMI_LINES lines
	assign evt[2] = tm.line_start & ((tm.v_count & NMI_MASK) == 9'd0);

	assign en = {ctrl.nmi_en, ctrl.firq_en, ctrl.irq_en};

	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			vblank_d <= 1'b1;  // Counters reset inside blank, no edge on release
			lat      <= '0;
		end else begin
			vblank_d <= tm.vblank;
			for (int i = 0; i < 3; i++) begin
				if (!en[i])
					lat[i] <= 1'b0;
				else if (evt[i])
					lat[i] <= 1'b1;
			end
		end
	end

	assign irq  = lat[0];
	assign firq = lat[1];
	assign nmi  = lat[2];

endmodule

// ==== k051960.sv ====
// Sprite chip subset with video timing, CPU registers, interrupts and ROM read-back
// Runs directly on clk_6M; V143 is the asynchronous active low reset
`timescale 1ns/1ns
`include "k051960_config.svh"

module k051960 (
	input  logic                     clk_6M,
	input  logic                     V143,
	input  logic                     cs,
	input  logic                     rd,
	input  logic                     wr,
	input  logic [`K051960_AB_W-1:0] ab,
	input  logic [`K051960_DB_W-1:0] db_in,
	output logic [`K051960_DB_W-1:0] db_out,
	output logic                     db_dir,
	output logic [`K051960_CA_W-1:0] ca,
	output logic [8:0]               hp,
	output logic [7:0]               vp,
	output logic                     vblank,
	output logic                     irq,
	output logic                     firq,
	output logic                     nmi
);

	video_timing_if tm ();

	k051960_pkg::ctrl_t ctrl;

	video_timing u_timing (
		.clk_6M (clk_6M),
		.V143   (V143),
		.tm     (tm.source)
	);

	sprite_regs u_regs (
		.clk_6M (clk_6M),
		.V143   (V143),
		.cs     (cs),
		.rd     (rd),
		.wr     (wr),
		.ab     (ab),
		.db_in  (db_in),
		.db_out (db_out),
		.db_dir (db_dir),
		.ca     (ca),
		.ctrl   (ctrl),
		.tm     (tm.ctrl)
	);

	irq_gen u_irq (
		.clk_6M (clk_6M),
		.V143   (V143),
		.ctrl   (ctrl),
		.tm     (tm.sink),
		.irq    (irq),
		.firq   (firq),
		.nmi    (nmi)
	);

	assign hp     = tm.h_count;
	assign vp     = tm.v_pos;   // Flip already applied
	assign vblank = tm.vblank;

endmodule

// ==== k051960_config.svh ====
// Counter ranges keep the chip's non-zero start values for H and V
// NMI spacing must stay a power of two since it masks V
`ifndef K051960_CONFIG_SVH
`define K051960_CONFIG_SVH

// Horizontal count, 384 pixels per line
`define K051960_H_START 128
`define K051960_H_END 511

// Vertical count, 264 lines per frame
`define K051960_V_START 248
`define K051960_V_END 511

// Blank window wraps through V_END back to V_START
`define K051960_VBLANK_START 496
`define K051960_VBLANK_END 271

`define K051960_NMI_LINES 32

// CPU address, CPU data and graphics ROM address
`define K051960_AB_W 11
`define K051960_DB_W 8
`define K051960_CA_W 18

`endif

// ==== k051960_pkg.sv ====
// Types shared by the register block and the interrupt generator
// Control register layout matches the byte the CPU writes at address 0
package k051960_pkg;

	// Register select from the low three CPU address bits
	typedef enum logic [2:0] {
		REG_CTRL    = 3'd0,
		REG_BANK_LO = 3'd2,
		REG_BANK_HI = 3'd3
	} reg_sel_e;

	// Bit 0 at the bottom, as on the data bus
	typedef struct packed {
		logic [1:0] spare;    // Bits 7:6, only read back
		logic       rom_read; // Bit 5, CPU reads graphics ROM
		logic       unused4;  // Bit 4
		logic       flip;     // Bit 3, screen flip
		logic       nmi_en;   // Bit 2
		logic       firq_en;  // Bit 1
		logic       irq_en;   // Bit 0
	} ctrl_t;

endpackage

// ==== k051960_properties.sv ====
// Concurrent checks bound into k051960, all disabled while V143 is low
// assert_fail_count is read by the testbench at the end of the run
`timescale 1ns/1ns
`include "k051960_config.svh"

module k051960_properties (
	input logic                     clk_6M,
	input logic                     V143,
	input k051960_pkg::ctrl_t       ctrl,
	input logic                     irq,
	input logic [`K051960_CA_W-1:0] ca,
	input logic [8:0]               hp
);

	int assert_fail_count = 0;

	// Latch may still show for the cycle the enable drops
	irq_needs_enable: assert property (@(posedge clk_6M) disable iff (!V143)
		!ctrl.irq_en |=> !irq)
		else begin
			assert_fail_count++;
			$error("irq stayed high with irq_en clear");
		end

	ca_idle_zero: assert property (@(posedge clk_6M) disable iff (!V143)
		!ctrl.rom_read |=> (ca == '0))
		else begin
			assert_fail_count++;
			$error("ca not zero one cycle after rom_read cleared");
		end

	hp_in_range: assert property (@(posedge clk_6M) disable iff (!V143)
		(hp >= `K051960_H_START) && (hp <= `K051960_H_END))
		else begin
			assert_fail_count++;
			$error("hp left the line range");
		end

endmodule

bind k051960 k051960_properties u_props (
	.clk_6M (clk_6M),
	.V143   (V143),
	.ctrl   (ctrl),
	.irq    (irq),
	.ca     (ca),
	.hp     (hp)
);

// ==== sim.f ====
+incdir+.
k051960_pkg.sv
video_timing_if.sv
video_timing.sv
sprite_regs.sv
irq_gen.sv
k051960.sv
k051960_properties.sv
tb_k051960.sv

// ==== sprite_regs.sv ====
// CPU side registers, strobes are active high levels sampled on clk_6M
// Only address 0 reads back; ROM read-back address needs rom_read and AB10
`timescale 1ns/1ns
`include "k051960_config.svh"

module sprite_regs (
	input  logic                         clk_6M,
	input  logic                         V143,
	input  logic                         cs,
	input  logic                         rd,
	input  logic                         wr,
	input  logic [`K051960_AB_W-1:0]     ab,
	input  logic [`K051960_DB_W-1:0]     db_in,
	output logic [`K051960_DB_W-1:0]     db_out,
	output logic                         db_dir,
	output logic [`K051960_CA_W-1:0]     ca,
	output k051960_pkg::ctrl_t           ctrl,
	video_timing_if.ctrl                 tm
);

	k051960_pkg::reg_sel_e reg_sel;
	k051960_pkg::ctrl_t    ctrl_q;
	logic [7:0] bank_lo;
	logic [1:0] bank_hi;  // Only two bits reach the ROM address
	logic       reg_hit;
	logic       reg_wr;
	logic       ctrl_rd;
	logic       rom_acc;

	// Registers live at 0..7 only
	assign reg_hit = (ab[`K051960_AB_W-1:3] == '0);
	assign reg_sel = k051960_pkg::reg_sel_e'(ab[2:0]);
	assign reg_wr  = cs & wr & reg_hit;
	assign ctrl_rd = cs & rd & reg_hit & (reg_sel == k051960_pkg::REG_CTRL);

	// Upper half of the window while ROM reading is on
	assign rom_acc = ctrl_q.rom_read & cs & ab[`K051960_AB_W-1];

	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			ctrl_q  <= '0;
			bank_lo <= '0;
			bank_hi <= '0;
		end else if (reg_wr) begin
			case (reg_sel)
				k051960_pkg::REG_CTRL:    ctrl_q  <= k051960_pkg::ctrl_t'(db_in);
				k051960_pkg::REG_BANK_LO: bank_lo <= db_in;
				k051960_pkg::REG_BANK_HI: bank_hi <= db_in[1:0];
				default: ;            // Addresses 1, 4..7 ignored
			endcase
		end
	end

	// Read-back, one clock behind rd
	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			db_out <= '0;
			db_dir <= 1'b0;
		end else begin
			db_dir <= ctrl_rd;
			db_out <= ctrl_rd ? ctrl_q : '0;
		end
	end

	// ROM address, bank bits on top and AB9..2 as the byte offset
	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			ca <= '0;
		end else if (!ctrl_q.rom_read) begin
			ca <= '0;                       // Render side not modelled
		end else if (rom_acc) begin
			ca <= {bank_hi, bank_lo, ab[9:2]};
		end
	end

	assign ctrl    = ctrl_q;
	assign tm.flip = ctrl_q.flip;

endmodule

// ==== tb_k051960.sv ====
// Inputs change on the rising edge, outputs are sampled on the falling edge
// Table entries carry random bank and control values from a fixed seed
`timescale 1ns/1ns
`include "k051960_config.svh"

module tb_k051960;

	localparam int LINE    = `K051960_H_END - `K051960_H_START + 1;
	localparam int LINES   = `K051960_V_END - `K051960_V_START + 1;
	localparam int FRAME   = LINE * LINES;
	localparam int FLIP_HP = 200;   // Sample point for vp within a line

	typedef enum int {OP_WRITE, OP_READ, OP_ROM, OP_WAIT, OP_LINES} op_e;

	typedef struct {
		op_e   op;
		int    addr;      // Bus address, or 0/1/2 for irq/firq/nmi on OP_WAIT
		int    data;      // Write data, wait timeout or line count
		int    expected;
		string name;
	} entry_t;

	logic        clk_6M;
	logic        V143;
	logic        cs;
	logic        rd;
	logic        wr;
	logic [10:0] ab;
	logic [7:0]  db_in;
	logic [7:0]  db_out;
	logic        db_dir;
	logic [17:0] ca;
	logic [8:0]  hp;
	logic [7:0]  vp;
	logic        vblank;
	logic        irq;
	logic        firq;
	logic        nmi;

	entry_t     table_q[$];
	logic [7:0] vp_ref;   // vp captured with flip clear
	int         errors = 0;
	int         passed = 0;
	int         failed = 0;

	k051960 uut (
		.clk_6M (clk_6M),
		.V143   (V143),
		.cs     (cs),
		.rd     (rd),
		.wr     (wr),
		.ab     (ab),
		.db_in  (db_in),
		.db_out (db_out),
		.db_dir (db_dir),
		.ca     (ca),
		.hp     (hp),
		.vp     (vp),
		.vblank (vblank),
		.irq    (irq),
		.firq   (firq),
		.nmi    (nmi)
	);

	initial begin
		clk_6M = 1'b0;
		forever #10 clk_6M = ~clk_6M;
	end

	task automatic compare_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	// One access of two clocks, returns after the registered response settled
	task automatic bus_cycle(input logic r, input logic w, input int addr, input int data);
		@(posedge clk_6M);
		cs    <= 1'b1;
		rd    <= r;
		wr    <= w;
		ab    <= 11'(addr);
		db_in <= 8'(data);
		@(posedge clk_6M);
		cs <= 1'b0;
		rd <= 1'b0;
		wr <= 1'b0;
		@(negedge clk_6M);
	endtask

	function automatic logic [7:0] ctrl_byte(input logic irq_en, input logic firq_en,
			input logic nmi_en, input logic flip, input logic rom_read);
		k051960_pkg::ctrl_t c;
		c          = '0;
		c.irq_en   = irq_en;
		c.firq_en  = firq_en;
		c.nmi_en   = nmi_en;
		c.flip     = flip;
		c.rom_read = rom_read;
		return c;
	endfunction

	function automatic logic int_line_level(input int sel);
		case (sel)
			0:       return irq;
			1:       return firq;
			default: return nmi;
		endcase
	endfunction

	function automatic void add_entry(input op_e op, input int addr, input int data,
			input int expected, input string name);
		entry_t e;
		e.op       = op;
		e.addr     = addr;
		e.data     = data;
		e.expected = expected;
		e.name     = name;
		table_q.push_back(e);
	endfunction

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			passed++;
			$display("test %0d %s: pass", passed + failed, name);
		end else begin
			failed++;
			$display("test %0d %s: fail", passed + failed, name);
		end
	endtask

	task automatic check_reset_state();
		@(negedge clk_6M);
		compare_value("irq after reset", irq, 0);
		compare_value("firq after reset", firq, 0);
		compare_value("nmi after reset", nmi, 0);
		compare_value("db_dir after reset", db_dir, 0);
		compare_value("ca after reset", ca, 0);
		for (int i = 0; i < 8; i++) begin
			compare_value("hp counting from H_START", hp, `K051960_H_START + i);
			@(negedge clk_6M);
		end
	endtask

	task automatic run_entry(input entry_t e);
		int         n;
		int         lines;
		int         vb_rise;
		logic       vb_prev;
		logic [7:0] vp_exp;
		case (e.op)
			OP_WRITE: bus_cycle(1'b0, 1'b1, e.addr, e.data);
			OP_READ: begin
				bus_cycle(1'b1, 1'b0, e.addr, 0);
				compare_value({e.name, " db_out"}, db_out, e.expected);
				compare_value({e.name, " db_dir"}, db_dir, 1);
				@(negedge clk_6M);   // rd already low for one clock
				compare_value({e.name, " db_dir after rd"}, db_dir, 0);
				compare_value({e.name, " db_out after rd"}, db_out, 0);
			end
			OP_ROM: begin
				bus_cycle(1'b0, 1'b0, e.addr, 0);
				compare_value({e.name, " ca"}, ca, e.expected);
			end
			OP_WAIT: begin
				n       = 0;
				vb_rise = -2;
				vb_prev = vblank;
				do begin
					@(negedge clk_6M);
					n++;
					if (vblank && !vb_prev)
						vb_rise = n;
					vb_prev = vblank;
				end while (int_line_level(e.addr) !== 1'(e.expected) && n < e.data);
				if (int_line_level(e.addr) !== 1'(e.expected)) begin
					$display("Timeout after %0d cycles: %s never reached level %0d",
						n, e.name, e.expected);
					errors++;
				end else if (e.expected == 1) begin
					if (e.addr == 0) begin
						compare_value("irq cycles after vblank rise", n - vb_rise, 1);
						compare_value("vblank while irq set", vblank, 1);
						compare_value("irq on first blank line", vp,
							`K051960_VBLANK_START % 256);
					end else if (e.addr == 1) begin
						compare_value("firq on an even line", vp[0], 0);
					end else begin
						compare_value("nmi line low bits", vp[4:0], 0);
					end
				end
			end
			OP_LINES: begin
				n     = 0;
				lines = 0;
				while (lines < e.data && n < (e.data + 1) * LINE) begin
					@(negedge clk_6M);
					n++;
					if (hp == `K051960_H_START)
						lines++;
				end
				n = 0;
				while (hp != FLIP_HP && n < LINE) begin
					@(negedge clk_6M);
					n++;
				end
				if (lines < e.data || hp != FLIP_HP) begin
					$display("Timeout while counting line starts for %s", e.name);
					errors++;
				end else if (e.addr == 0) begin
					vp_ref = vp;
				end else begin
					vp_exp = ~vp_ref;
					compare_value("vp with flip set", vp, vp_exp);
				end
			end
			default: ;
		endcase
	endtask

	initial begin
		int          seed;
		int          errs_before;
		logic [7:0]  rnd_ctrl;
		logic [7:0]  bank_lo;
		logic [7:0]  bank_hi;
		logic [10:0] rom_a;
		logic [10:0] rom_b;
		V143   = 1'b0;
		cs     = 1'b0;
		rd     = 1'b0;
		wr     = 1'b0;
		ab     = '0;
		db_in  = '0;
		vp_ref = '0;
		seed     = 92;
		rnd_ctrl = 8'($random(seed));
		bank_lo  = 8'($random(seed));
		bank_hi  = 8'($random(seed));
		rom_a    = 11'h400 | 11'($random(seed));   // Upper half of the window
		rom_b    = 11'h400 | 11'($random(seed));

		add_entry(OP_WRITE, 0, rnd_ctrl, 0, "ctrl write");
		add_entry(OP_READ, 0, 0, rnd_ctrl, "ctrl read-back");
		add_entry(OP_WRITE, 1, ~rnd_ctrl, 0, "write to address 1");
		add_entry(OP_WRITE, 8, ~rnd_ctrl, 0, "write to address 8");
		add_entry(OP_READ, 0, 0, rnd_ctrl, "ctrl unchanged");
		add_entry(OP_WRITE, 2, bank_lo, 0, "bank lo write");
		add_entry(OP_WRITE, 3, bank_hi, 0, "bank hi write");
		add_entry(OP_WRITE, 0, ctrl_byte(0, 0, 0, 0, 1), 0, "rom_read on");
		add_entry(OP_ROM, rom_a, 0, int'({bank_hi[1:0], bank_lo, rom_a[9:2]}), "rom address a");
		add_entry(OP_ROM, rom_b, 0, int'({bank_hi[1:0], bank_lo, rom_b[9:2]}), "rom address b");
		add_entry(OP_WRITE, 0, 0, 0, "rom_read off");
		add_entry(OP_ROM, rom_a, 0, 0, "rom address idle");
		add_entry(OP_LINES, 0, 1, 0, "vp reference");
		add_entry(OP_WRITE, 0, ctrl_byte(0, 0, 0, 1, 0), 0, "flip on");
		add_entry(OP_LINES, 1, LINES, 0, "vp flipped");   // Same line one frame later
		add_entry(OP_WRITE, 0, ctrl_byte(1, 0, 0, 0, 0), 0, "irq enable");
		add_entry(OP_WAIT, 0, FRAME + 2, 1, "irq rise");
		add_entry(OP_WRITE, 0, 0, 0, "irq disable");
		add_entry(OP_WAIT, 0, 1, 0, "irq clear");
		add_entry(OP_WRITE, 0, ctrl_byte(0, 1, 1, 0, 0), 0, "firq and nmi enable");
		add_entry(OP_WAIT, 1, 2 * LINE + 2, 1, "firq rise");
		add_entry(OP_WAIT, 2, `K051960_NMI_LINES * LINE + 2, 1, "nmi rise");
		add_entry(OP_WRITE, 0, ctrl_byte(0, 0, 1, 0, 0), 0, "firq disable");
		add_entry(OP_WAIT, 1, 1, 0, "firq clear");
		add_entry(OP_WRITE, 0, 0, 0, "nmi disable");
		add_entry(OP_WAIT, 2, 1, 0, "nmi clear");

		repeat (16) @(posedge clk_6M);
		V143 <= 1'b1;
		errs_before = errors;
		check_reset_state();
		report_test("reset state", errs_before);

		// Writes only set up the checks that follow them
		foreach (table_q[i]) begin
			errs_before = errors;
			run_entry(table_q[i]);
			if (table_q[i].op != OP_WRITE)
				report_test(table_q[i].name, errs_before);
		end

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors, %0d assertion failures",
			passed + failed, passed, failed, errors, uut.u_props.assert_fail_count);
		if (errors == 0 && uut.u_props.assert_fail_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== video_timing.sv ====
// Free running H/V counters on clk_6M, no external sync or chaining
// vblank comes out of a register, line_start and v_pos are decoded from the counters
`timescale 1ns/1ns
`include "k051960_config.svh"

module video_timing (
	input  logic clk_6M,
	input  logic V143,
	video_timing_if.source tm
);

	localparam logic [8:0] H_START  = 9'(`K051960_H_START);
	localparam logic [8:0] H_END    = 9'(`K051960_H_END);
	localparam logic [8:0] V_START  = 9'(`K051960_V_START);
	localparam logic [8:0] V_END    = 9'(`K051960_V_END);
	localparam logic [8:0] VB_START = 9'(`K051960_VBLANK_START);
	localparam logic [8:0] VB_END   = 9'(`K051960_VBLANK_END);

	logic [8:0] h_count;
	logic [8:0] v_count;
	logic [8:0] h_next;
	logic [8:0] v_next;
	logic       h_wrap;
	logic       vblank;

	// Window spans the frame wrap, V is always >= V_START
	function automatic logic in_blank(input logic [8:0] v);
		in_blank = (v >= VB_START) || (v <= VB_END);
	endfunction

	assign h_wrap = (h_count == H_END);

	always_comb begin
		h_next = h_wrap ? H_START : h_count + 9'd1;
		v_next = v_count;
		if (h_wrap) begin
			if (v_count == V_END)
				v_next = V_START;
			else
				v_next = v_count + 9'd1;
		end
	end

	// Blank follows the new V so it changes on the same edge as the counter
	always_ff @(posedge clk_6M or negedge V143) begin
		if (!V143) begin
			h_count <= H_START;
			v_count <= V_START;
			vblank  <= in_blank(V_START); // First line already in blank
		end else begin
			h_count <= h_next;
			v_count <= v_next;
			vblank  <= in_blank(v_next);
		end
	end

	assign tm.h_count    = h_count;
	assign tm.v_count    = v_count;
	assign tm.vblank     = vblank;
	assign tm.line_start = (h_count == H_START);

	// Flipped screen counts lines backwards
	assign tm.v_pos = v_count[7:0] ^ {8{tm.flip}};

endmodule

// ==== video_timing_if.sv ====
// Timing bus from the counters to the register block and the interrupt logic
// flip comes back from the control register, everything else from the counters
`timescale 1ns/1ns

interface video_timing_if;

	logic [8:0] h_count;    // 128..511
	logic [8:0] v_count;    // 248..511, never flipped
	logic [7:0] v_pos;      // Low V bits after flip
	logic       vblank;
	logic       line_start; // High for the H_START clock
	logic       flip;

	modport source (
		output h_count, v_count, v_pos, vblank, line_start,
		input  flip
	);

	modport ctrl (
		output flip
	);

	modport sink (
		input h_count, v_count, vblank, line_start
	);

endinterface
